//--- logic/rv_fetch_pkg.sv
/*
  Shared widths, opcodes and limits of the RV32 fetch front end.
  The FIFO depth must be a power of two, and CREDIT_W must hold the depth itself.
  RV32 only. No float and no RV64 encodings are known here.
*/
`default_nettype none

package rv_fetch_pkg;

  // payload widths
  typedef logic [31:0] fetch_word_t;  // aligned word from memory
  typedef logic [31:0] instr_t;       // rv32 or zero extended rvc
  typedef logic [15:0] half_t;        // one 16-bit parcel

  // rv32 major opcodes produced by the expander
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;

  // word fifo depth and initial input credit count of the sender
  localparam int WORD_FIFO_DEPTH = 4;
  // credit counters count 0..depth inclusive
  localparam int CREDIT_W        = 3;
  // upper bound of output grants outstanding at the consumer
  localparam int OUT_CREDITS_MAX = 4;

  // realigner holds at most one leftover upper halfword
  typedef enum logic [1:0] {
    EMPTY,
    HALF_HELD
  } realign_state_t;

endpackage

`default_nettype wire

//--- logic/fetch_ingress.sv
/*
  Input stage of the fetch front end.
  The sender holds WORD_FIFO_DEPTH credits after reset and spends one per word.
  A credit returns one cycle after the word leaves the FIFO.
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_ingress
  import rv_fetch_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        word_valid_i,
  input  wire fetch_word_t word_i,
  input  wire logic        fifo_pop_i,
  output logic             push_o,
  output fetch_word_t      push_data_o,
  output logic             word_credit_o
);

  // credits still held by the sender
  logic [CREDIT_W-1:0] held_cnt_q;

  // one register stage in front of the fifo
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      push_o        <= 1'b0;
      word_credit_o <= 1'b0;
    end else begin
      push_o        <= word_valid_i;
      // every pop frees one slot for the sender
      word_credit_o <= fifo_pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      push_data_o <= word_i;
    end
  end

  // mirror of the sender's credit pool
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_cnt_q <= CREDIT_W'(WORD_FIFO_DEPTH);
    end else begin
      case ({word_valid_i, word_credit_o})
        2'b10:   held_cnt_q <= held_cnt_q - 1'b1;
        2'b01:   held_cnt_q <= held_cnt_q + 1'b1;
        default: held_cnt_q <= held_cnt_q;
      endcase
    end
  end

  // sender must own a credit for every word it sends
  a_word_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_valid_i |-> (held_cnt_q != '0))
    else $error("fetch word sent without an input credit");

  // returned credits never push the pool above the fifo depth
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    held_cnt_q <= CREDIT_W'(WORD_FIFO_DEPTH))
    else $error("input credit count above fifo depth");

endmodule

`default_nettype wire

//--- logic/instr_word_fifo.sv
/*
  Synchronous circular FIFO of fetch words.
  Overflow is prevented by the input credits, so push never checks for full.
  Read data is taken straight from the storage array without a register.
*/
`timescale 1ns/10ps
`default_nettype none

module instr_word_fifo
  import rv_fetch_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        push_i,
  input  wire fetch_word_t push_data_i,
  input  wire logic        pop_i,
  output logic             pop_valid_o,
  output fetch_word_t      pop_data_o
);

  // storage
  fetch_word_t mem_q [WORD_FIFO_DEPTH];

  // pointers are one bit narrower than the occupancy count
  logic [CREDIT_W-2:0] wr_ptr_q;
  logic [CREDIT_W-2:0] rd_ptr_q;
  logic [CREDIT_W-1:0] count_q;

  ////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap on their own width
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // head of queue
  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_q < CREDIT_W'(WORD_FIFO_DEPTH)))
    else $error("push into a full word fifo");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (count_q != '0))
    else $error("pop from an empty word fifo");

endmodule

`default_nettype wire

//--- logic/instr_realigner.sv
/*
  Splits the aligned word stream into 16-bit and 32-bit instructions.
  A word is popped as soon as its upper halfword is captured or used.
  raw_valid_o is combinational and is set only while an output credit is held.
*/
`timescale 1ns/10ps
`default_nettype none

module instr_realigner
  import rv_fetch_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        word_valid_i,
  input  wire fetch_word_t word_i,
  output logic             word_pop_o,
  input  wire logic        instr_credit_i,
  output logic             raw_valid_o,
  output instr_t           raw_instr_o
);

  realign_state_t state_q, state_d;
  half_t          held_q, held_d;
  half_t          word_lo;
  half_t          word_hi;
  logic           have_credit;
  // output grants not yet used
  logic [CREDIT_W-1:0] out_cnt_q;

  assign word_lo     = word_i[15:0];
  assign word_hi     = word_i[31:16];
  assign have_credit = (out_cnt_q != '0);

  ////////////////////////////////////////////////////////////
  // parcel selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    held_d      = held_q;
    word_pop_o  = 1'b0;
    raw_valid_o = 1'b0;
    raw_instr_o = {16'h0000, word_lo};
    case (state_q)
      EMPTY: begin
        if (word_lo[1:0] == 2'b11) begin
          // aligned 32-bit instruction
          raw_instr_o = word_i;
        end
        if (word_valid_i && have_credit) begin
          raw_valid_o = 1'b1;
          word_pop_o  = 1'b1;
          if (word_lo[1:0] != 2'b11) begin
            // keep the upper parcel for the next cycle
            held_d  = word_hi;
            state_d = HALF_HELD;
          end
        end
      end
      HALF_HELD: begin
        if (held_q[1:0] == 2'b11) begin
          // 32-bit instruction straddles the held parcel and the new word
          raw_instr_o = {word_lo, held_q};
          if (word_valid_i && have_credit) begin
            raw_valid_o = 1'b1;
            word_pop_o  = 1'b1;
            held_d      = word_hi;
          end
        end else begin
          // held parcel is a complete rvc instruction
          raw_instr_o = {16'h0000, held_q};
          if (have_credit) begin
            raw_valid_o = 1'b1;
            state_d     = EMPTY;
          end
        end
      end
      default: state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= EMPTY;
      out_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      case ({instr_credit_i, raw_valid_o})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  // leftover parcel
  always_ff @(posedge clk_i) begin
    held_q <= held_d;
  end

  // consumer grants stay within its own slot count
  a_out_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_cnt_q <= CREDIT_W'(OUT_CREDITS_MAX))
    else $error("output credit counter overflow");

endmodule

`default_nettype wire

//--- logic/compressed_decoder.sv
/*
  Combinational RVC to RV32I expander.
  Hints expand like their base forms and stay legal.
  Float, RV64 and reserved encodings raise illegal_instr_o.
  The instruction word of an illegal encoding is not defined.
*/
`timescale 1ns/10ps
`default_nettype none

module compressed_decoder
  import rv_fetch_pkg::*;
(
  input  wire instr_t instr_i,
  output instr_t      instr_o,
  output logic        is_compressed_o,
  output logic        illegal_instr_o
);

  // lower parcel holds the whole rvc encoding
  half_t ci;

  assign ci              = instr_i[15:0];
  assign is_compressed_o = (ci[1:0] != 2'b11);

  always_comb begin
    instr_o         = instr_i;
    illegal_instr_o = 1'b0;
    case (ci[1:0])
      ////////////////////////////////////////////////////////////
      // quadrant C0
      ////////////////////////////////////////////////////////////
      2'b00: begin
        case (ci[15:13])
          3'b000: begin
            // c.addi4spn to addi rd', x2, nzuimm
            instr_o = {2'b00, ci[10:7], ci[12:11], ci[5], ci[6], 2'b00,
                       5'd2, 3'b000, 2'b01, ci[4:2], OPCODE_OPIMM};
            // zero immediate is reserved
            illegal_instr_o = (ci[12:5] == 8'h00);
          end
          3'b010: begin
            // c.lw
            instr_o = {5'b0, ci[5], ci[12:10], ci[6], 2'b00,
                       2'b01, ci[9:7], 3'b010, 2'b01, ci[4:2], OPCODE_LOAD};
          end
          3'b110: begin
            // c.sw
            instr_o = {5'b0, ci[5], ci[12], 2'b01, ci[4:2], 2'b01, ci[9:7],
                       3'b010, ci[11:10], ci[6], 2'b00, OPCODE_STORE};
          end
          // float loads and stores and the reserved slot
          default: illegal_instr_o = 1'b1;
        endcase
      end

      ////////////////////////////////////////////////////////////
      // quadrant C1
      ////////////////////////////////////////////////////////////
      2'b01: begin
        case (ci[15:13])
          3'b000: begin
            // c.addi and c.nop
            instr_o = {{7{ci[12]}}, ci[6:2], ci[11:7], 3'b000, ci[11:7], OPCODE_OPIMM};
          end
          3'b001, 3'b101: begin
            // c.jal links x1 and c.j links x0
            instr_o = {ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11], ci[5:3],
                       {9{ci[12]}}, 4'b0000, ~ci[15], OPCODE_JAL};
          end
          3'b010: begin
            // c.li with rd of x0 as a hint
            instr_o = {{7{ci[12]}}, ci[6:2], 5'd0, 3'b000, ci[11:7], OPCODE_OPIMM};
          end
          3'b011: begin
            if (ci[11:7] == 5'd2) begin
              // c.addi16sp
              instr_o = {{3{ci[12]}}, ci[4:3], ci[5], ci[2], ci[6], 4'b0000,
                         5'd2, 3'b000, 5'd2, OPCODE_OPIMM};
            end else begin
              // c.lui
              instr_o = {{15{ci[12]}}, ci[6:2], ci[11:7], OPCODE_LUI};
            end
            // zero immediate reserved for both forms
            illegal_instr_o = ({ci[12], ci[6:2]} == 6'd0);
          end
          3'b100: begin
            case (ci[11:10])
              2'b00, 2'b01: begin
                // c.srli and c.srai
                // shamt[5] set is rv64 only
                instr_o = {1'b0, ci[10], 5'b0, ci[6:2], 2'b01, ci[9:7],
                           3'b101, 2'b01, ci[9:7], OPCODE_OPIMM};
                illegal_instr_o = ci[12];
              end
              2'b10: begin
                // c.andi
                instr_o = {{7{ci[12]}}, ci[6:2], 2'b01, ci[9:7],
                           3'b111, 2'b01, ci[9:7], OPCODE_OPIMM};
              end
              default: begin
                // register-register ops on rd' and rs2'
                case ({ci[12], ci[6:5]})
                  3'b000: instr_o = {7'b0100000, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                     3'b000, 2'b01, ci[9:7], OPCODE_OP};
                  3'b001: instr_o = {7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                     3'b100, 2'b01, ci[9:7], OPCODE_OP};
                  3'b010: instr_o = {7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                     3'b110, 2'b01, ci[9:7], OPCODE_OP};
                  3'b011: instr_o = {7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                     3'b111, 2'b01, ci[9:7], OPCODE_OP};
                  // c.subw, c.addw and reserved
                  default: illegal_instr_o = 1'b1;
                endcase
              end
            endcase
          end
          default: begin
            // c.beqz and c.bnez take funct3 bit 0 from ci[13]
            instr_o = {{4{ci[12]}}, ci[6:5], ci[2], 5'd0, 2'b01, ci[9:7],
                       2'b00, ci[13], ci[11:10], ci[4:3], ci[12], OPCODE_BRANCH};
          end
        endcase
      end

      ////////////////////////////////////////////////////////////
      // quadrant C2
      ////////////////////////////////////////////////////////////
      2'b10: begin
        case (ci[15:13])
          3'b000: begin
            // c.slli
            instr_o = {7'b0, ci[6:2], ci[11:7], 3'b001, ci[11:7], OPCODE_OPIMM};
            illegal_instr_o = ci[12];
          end
          3'b010: begin
            // c.lwsp with rd of x0 reserved
            instr_o = {4'b0, ci[3:2], ci[12], ci[6:4], 2'b00,
                       5'd2, 3'b010, ci[11:7], OPCODE_LOAD};
            illegal_instr_o = (ci[11:7] == 5'd0);
          end
          3'b100: begin
            if (ci[6:2] == 5'd0) begin
              if (ci[12] == 1'b0) begin
                // c.jr
                instr_o = {12'h000, ci[11:7], 3'b000, 5'd0, OPCODE_JALR};
                illegal_instr_o = (ci[11:7] == 5'd0);
              end else if (ci[11:7] == 5'd0) begin
                // c.ebreak
                instr_o = 32'h0010_0073;
              end else begin
                // c.jalr
                instr_o = {12'h000, ci[11:7], 3'b000, 5'd1, OPCODE_JALR};
              end
            end else begin
              // c.mv adds to x0 and c.add adds to rd
              instr_o = {7'b0, ci[6:2], (ci[12] ? ci[11:7] : 5'd0), 3'b000,
                         ci[11:7], OPCODE_OP};
            end
          end
          3'b110: begin
            // c.swsp
            instr_o = {4'b0, ci[8:7], ci[12], ci[6:2], 5'd2, 3'b010,
                       ci[11:9], 2'b00, OPCODE_STORE};
          end
          // float stack loads and stores
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // full 32-bit instruction passes through
      default: instr_o = instr_i;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/fetch_frontend_top.sv
/*
  RV32 fetch front end with credit flow control on both sides.
  The stream is strictly sequential and carries no program counter.
  First instr_valid_o comes at least 3 cycles after its word arrives.
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_top
  import rv_fetch_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        word_valid_i,
  input  wire fetch_word_t word_i,
  output logic             word_credit_o,
  input  wire logic        instr_credit_i,
  output logic             instr_valid_o,
  output instr_t           instr_o,
  output logic             is_compressed_o,
  output logic             illegal_instr_o
);

  logic        push;
  fetch_word_t push_data;
  logic        fifo_pop;
  logic        pop_valid;
  fetch_word_t pop_data;
  logic        raw_valid;
  instr_t      raw_instr;
  // decoder results
  instr_t      dec_instr;
  logic        dec_compressed;
  logic        dec_illegal;

  fetch_ingress u_ingress (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .word_valid_i  (word_valid_i),
    .word_i        (word_i),
    .fifo_pop_i    (fifo_pop),
    .push_o        (push),
    .push_data_o   (push_data),
    .word_credit_o (word_credit_o)
  );

  instr_word_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (fifo_pop),
    .pop_valid_o (pop_valid),
    .pop_data_o  (pop_data)
  );

  instr_realigner u_realigner (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .word_valid_i   (pop_valid),
    .word_i         (pop_data),
    .word_pop_o     (fifo_pop),
    .instr_credit_i (instr_credit_i),
    .raw_valid_o    (raw_valid),
    .raw_instr_o    (raw_instr)
  );

  compressed_decoder u_decoder (
    .instr_i         (raw_instr),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_compressed),
    .illegal_instr_o (dec_illegal)
  );

  // output register, loaded in the cycle the credit is spent
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_valid_o <= 1'b0;
    end else begin
      instr_valid_o <= raw_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (raw_valid) begin
      instr_o         <= dec_instr;
      is_compressed_o <= dec_compressed;
      illegal_instr_o <= dec_illegal;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/*
  Free running 8 ns clock and an active low reset.
  Reset is released after 8 rising edges.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // half period of 4 ns
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    // release away from the edge
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/rvc_ref_model.svh
/*
  Reference RVC expansion built from the ISA field layout, and an xorshift step.
  RV32C only. The instruction word of an illegal encoding is not defined here.
*/
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected rv32 word and legality of one raw instruction
function automatic instr_t rvc_ref_expand(input instr_t raw, output logic illegal);
  half_t       c;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm;
  logic [20:0] jimm;
  logic [12:0] bimm;
  logic [6:0]  f7;
  logic [2:0]  f3;
  instr_t      r;
  c       = raw[15:0];
  rdp     = {2'b01, c[4:2]};
  rs1p    = {2'b01, c[9:7]};
  rd      = c[11:7];
  rs2     = c[6:2];
  illegal = 1'b0;
  r       = raw;
  if (c[1:0] == 2'b11) begin
    return raw;
  end
  case ({c[1:0], c[15:13]})
    // quadrant 0
    5'b00_000: begin
      imm     = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
      r       = {imm, 5'd2, 3'b000, rdp, OPCODE_OPIMM};
      illegal = (imm == 12'd0);
    end
    5'b00_010: begin
      imm = {5'd0, c[5], c[12:10], c[6], 2'b00};
      r   = {imm, rs1p, 3'b010, rdp, OPCODE_LOAD};
    end
    5'b00_110: begin
      imm = {5'd0, c[5], c[12:10], c[6], 2'b00};
      r   = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], OPCODE_STORE};
    end
    // quadrant 1
    5'b01_000: begin
      imm = {{6{c[12]}}, c[12], c[6:2]};
      r   = {imm, rd, 3'b000, rd, OPCODE_OPIMM};
    end
    5'b01_001, 5'b01_101: begin
      jimm = {{9{c[12]}}, c[12], c[8], c[10], c[9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
      r    = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], (c[15] ? 5'd0 : 5'd1), OPCODE_JAL};
    end
    5'b01_010: begin
      imm = {{6{c[12]}}, c[12], c[6:2]};
      r   = {imm, 5'd0, 3'b000, rd, OPCODE_OPIMM};
    end
    5'b01_011: begin
      if (rd == 5'd2) begin
        imm = {{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
        r   = {imm, 5'd2, 3'b000, 5'd2, OPCODE_OPIMM};
      end else begin
        r = {{14{c[12]}}, c[12], c[6:2], rd, OPCODE_LUI};
      end
      illegal = ({c[12], c[6:2]} == 6'd0);
    end
    5'b01_100: begin
      case (c[11:10])
        2'b00, 2'b01: begin
          f7      = c[10] ? 7'b0100000 : 7'b0000000;
          r       = {f7, rs2, rs1p, 3'b101, rs1p, OPCODE_OPIMM};
          illegal = c[12];
        end
        2'b10: begin
          imm = {{6{c[12]}}, c[12], c[6:2]};
          r   = {imm, rs1p, 3'b111, rs1p, OPCODE_OPIMM};
        end
        default: begin
          f7 = (c[6:5] == 2'b00) ? 7'b0100000 : 7'b0000000;
          case (c[6:5])
            2'b00:   f3 = 3'b000;
            2'b01:   f3 = 3'b100;
            2'b10:   f3 = 3'b110;
            default: f3 = 3'b111;
          endcase
          r       = {f7, rdp, rs1p, f3, rs1p, OPCODE_OP};
          illegal = c[12];
        end
      endcase
    end
    5'b01_110, 5'b01_111: begin
      bimm = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
      r    = {bimm[12], bimm[10:5], 5'd0, rs1p, {2'b00, c[13]}, bimm[4:1], bimm[11],
              OPCODE_BRANCH};
    end
    // quadrant 2
    5'b10_000: begin
      r       = {7'd0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
      illegal = c[12];
    end
    5'b10_010: begin
      imm     = {4'd0, c[3:2], c[12], c[6:4], 2'b00};
      r       = {imm, 5'd2, 3'b010, rd, OPCODE_LOAD};
      illegal = (rd == 5'd0);
    end
    5'b10_100: begin
      if (rs2 != 5'd0) begin
        // c.mv and c.add
        r = {7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, OPCODE_OP};
      end else if (!c[12]) begin
        r       = {12'd0, rd, 3'b000, 5'd0, OPCODE_JALR};
        illegal = (rd == 5'd0);
      end else if (rd == 5'd0) begin
        r = 32'h0010_0073;
      end else begin
        r = {12'd0, rd, 3'b000, 5'd1, OPCODE_JALR};
      end
    end
    5'b10_110: begin
      imm = {4'd0, c[8:7], c[12:9], 2'b00};
      r   = {imm[11:5], rs2, 5'd2, 3'b010, imm[4:0], OPCODE_STORE};
    end
    // float, rv64 and reserved slots
    default: illegal = 1'b1;
  endcase
  return r;
endfunction

`endif

//--- testbench/fetch_frontend_tb.sv
/*
  Testbench of the fetch front end with credit flow on both sides.
  Expected results come from the reference expander, matched in program order.
  A trailing odd parcel is padded with c.nop so every word is complete.
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_tb
  import rv_fetch_pkg::*;
();

  `include "rvc_ref_model.svh"

  localparam int N_ALIGNED = 24;
  localparam int N_RANDOM  = 160;
  localparam int N_LEGAL   = 32;
  localparam int N_ILLEGAL = 17;

  // legal rvc forms including hints and c.ebreak
  localparam logic [15:0] LEGAL_RVC [N_LEGAL] = '{
    16'h0040, 16'h4144, 16'hC144, 16'h0001, 16'h10FD, 16'h2001, 16'hA001, 16'hBFFD,
    16'h428D, 16'h4005, 16'h6141, 16'h6285, 16'h8005, 16'h8405, 16'h987D, 16'h8C05,
    16'h8C25, 16'h8C45, 16'h8C65, 16'hC001, 16'hE001, 16'hC011, 16'h0086, 16'h0006,
    16'h4082, 16'h8082, 16'h9082, 16'h9002, 16'h808A, 16'h800A, 16'h908A, 16'hC206};

  // reserved and float encodings
  localparam logic [15:0] ILLEGAL_RVC [N_ILLEGAL] = '{
    16'h0000, 16'h2000, 16'h6000, 16'hA000, 16'hE000, 16'h8000, 16'h6101, 16'h6281,
    16'h9005, 16'h9C05, 16'h1086, 16'h4002, 16'h8002, 16'h2002, 16'hA002, 16'h6002,
    16'hE002};

  logic        clk;
  logic        rst_n;
  logic        word_valid_i;
  fetch_word_t word_i;
  logic        word_credit_o;
  logic        instr_credit_i;
  logic        instr_valid_o;
  instr_t      instr_o;
  logic        is_compressed_o;
  logic        illegal_instr_o;

  // scoreboard
  instr_t      stim_q [$];
  fetch_word_t word_q [$];
  instr_t      exp_instr_q [$];
  logic        exp_comp_q [$];
  logic        exp_ill_q [$];

  int          held_credits;
  int          grants;
  int          valids;
  int          err_cnt;
  int          check_cnt;
  logic        running;
  logic        rand_mode;
  logic [31:0] rng;
  logic [31:0] grant_rng;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_frontend_top UUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .word_valid_i    (word_valid_i),
    .word_i          (word_i),
    .word_credit_o   (word_credit_o),
    .instr_credit_i  (instr_credit_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o)
  );

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_instr(input instr_t got, input instr_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // background processes
  ////////////////////////////////////////////////////////////

  // input credits come back one per pulse
  always @(negedge clk) begin
    if (rst_n && word_credit_o) begin
      held_credits++;
      if (held_credits > WORD_FIFO_DEPTH) begin
        err_cnt++;
        $display("at %0t ns more input credits came back than words were sent", $time);
      end
    end
  end

  // output grants stay within the consumer's slot count
  always @(posedge clk) begin
    grant_rng = xorshift32(grant_rng);
    if (running && (grants - valids < OUT_CREDITS_MAX) && (!rand_mode || grant_rng[2])) begin
      instr_credit_i <= 1'b1;
      grants++;
    end else begin
      instr_credit_i <= 1'b0;
    end
  end

  // compare every delivered instruction in program order
  always @(negedge clk) begin
    if (rst_n && instr_valid_o) begin
      valids++;
      if (valids > grants) begin
        err_cnt++;
        $display("at %0t ns an instruction came out without an output credit", $time);
      end
      if (exp_instr_q.size() == 0) begin
        err_cnt++;
        $display("at %0t ns an instruction came out that was never sent", $time);
      end else begin
        if (!exp_ill_q[0]) begin
          check_instr(instr_o, exp_instr_q[0], "instr_o");
        end
        check_flag(is_compressed_o, exp_comp_q[0], "is_compressed_o");
        check_flag(illegal_instr_o, exp_ill_q[0], "illegal_instr_o");
        void'(exp_instr_q.pop_front());
        void'(exp_comp_q.pop_front());
        void'(exp_ill_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // random 32-bit word with the rv32 length bits
  function automatic instr_t random_rv32(input logic [31:0] r);
    return {r[31:2], 2'b11};
  endfunction

  // sends stim_q as a word stream and waits until all of it came back
  task automatic run_test(input string name, input logic rnd);
    int          errs_before;
    int          parcels;
    int          n;
    logic        ill;
    instr_t      exp;
    half_t       parts [$];
    errs_before = err_cnt;
    parcels     = 0;
    foreach (stim_q[i]) begin
      parcels += (stim_q[i][1:0] == 2'b11) ? 2 : 1;
    end
    if (parcels % 2 != 0) begin
      stim_q.push_back(32'h0000_0001);
    end
    n = stim_q.size();
    foreach (stim_q[i]) begin
      exp = rvc_ref_expand(stim_q[i], ill);
      exp_instr_q.push_back(exp);
      exp_comp_q.push_back(stim_q[i][1:0] != 2'b11);
      exp_ill_q.push_back(ill);
      parts.push_back(stim_q[i][15:0]);
      if (stim_q[i][1:0] == 2'b11) begin
        parts.push_back(stim_q[i][31:16]);
      end
    end
    // the lower parcel sits in the lower half of the word
    for (int i = 0; i < parts.size(); i += 2) begin
      word_q.push_back({parts[i+1], parts[i]});
    end
    rand_mode <= rnd;
    while (word_q.size() != 0) begin
      @(posedge clk);
      rng = xorshift32(rng);
      if (held_credits > 0 && (!rand_mode || rng[5:4] != 2'b00)) begin
        word_valid_i <= 1'b1;
        word_i       <= word_q.pop_front();
        held_credits--;
      end else begin
        word_valid_i <= 1'b0;
      end
    end
    @(posedge clk);
    word_valid_i <= 1'b0;
    while (exp_instr_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    check_cnt++;
    if (held_credits != WORD_FIFO_DEPTH) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: input credits held %0d expected %0d",
               $time, held_credits, WORD_FIFO_DEPTH);
    end
    $display("test %s: %0d instructions, %0d errors", name, n, err_cnt - errs_before);
    stim_q.delete();
  endtask

  // watchdog sized from the number of instructions
  initial begin
    int limit;
    limit = (N_ALIGNED + N_LEGAL + N_ILLEGAL + 2 * N_RANDOM + 3) * 200;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the front end stopped delivering", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    word_valid_i   = 1'b0;
    word_i         = '0;
    instr_credit_i = 1'b0;
    held_credits   = WORD_FIFO_DEPTH;
    grants         = 0;
    valids         = 0;
    err_cnt        = 0;
    check_cnt      = 0;
    running        = 1'b0;
    rand_mode      = 1'b0;
    rng            = 32'haacb_1f43;
    grant_rng      = xorshift32(32'haacb_1f43);
    while (rst_n !== 1'b1) begin
      @(posedge clk);
    end
    @(posedge clk);
    running <= 1'b1;

    for (int i = 0; i < N_ALIGNED; i++) begin
      rng = xorshift32(rng);
      stim_q.push_back(random_rv32(rng));
    end
    run_test("aligned_rv32", 1'b0);

    for (int i = 0; i < N_LEGAL; i++) begin
      stim_q.push_back({16'h0000, LEGAL_RVC[i]});
    end
    run_test("legal_rvc", 1'b0);

    for (int i = 0; i < N_ILLEGAL; i++) begin
      stim_q.push_back({16'h0000, ILLEGAL_RVC[i]});
    end
    run_test("illegal_rvc", 1'b0);

    // random mix where 32-bit words straddle whenever the parcel count is odd
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < N_RANDOM; i++) begin
        rng = xorshift32(rng);
        if (rng[0]) begin
          stim_q.push_back(random_rv32(xorshift32(rng)));
        end else begin
          stim_q.push_back({16'h0000, rng[23:10], (rng[9:8] == 2'b11) ? 2'b01 : rng[9:8]});
        end
      end
      run_test(pass == 0 ? "random_mix" : "random_grants", pass == 1);
    end

    running <= 1'b0;
    @(negedge clk);
    $display("checks %0d, errors %0d, grants %0d, delivered %0d",
             check_cnt, err_cnt, grants, valids);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+testbench
logic/rv_fetch_pkg.sv
logic/fetch_ingress.sv
logic/instr_word_fifo.sv
logic/instr_realigner.sv
logic/compressed_decoder.sv
logic/fetch_frontend_top.sv
testbench/tb_clock_gen.sv
testbench/fetch_frontend_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = fetch_frontend_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
